// ==== source/alu.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module alu (
    input  rv_pkg::word_t      a,
    input  rv_pkg::word_t      b,
    input  rv_pkg::alu_op_t    op,
    output rv_pkg::word_t      result,
    output rv_pkg::alu_flags_t flags
);
    logic [32:0]   diff_ext;    // top bit is the unsigned borrow
    rv_pkg::word_t diff;
    rv_pkg::word_t sra;
    logic [4:0]    shamt;
    logic          alt;

    assign alt      = op[3];
    assign shamt    = b[4:0];
    assign diff_ext = {1'b0, a} - {1'b0, b};
    assign diff     = diff_ext[31:0];
    assign sra      = $signed(a) >>> shamt;

    assign flags.zero     = (diff == '0);
    assign flags.negative = diff[31];
    assign flags.overflow = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb begin
        case (op[2:0])
            `ALU_ADDSUB: result = alt ? diff : a + b;
            `ALU_SLL:    result = a << shamt;
            `ALU_SLT:    result = {31'b0, flags.negative ^ flags.overflow};
            `ALU_SLTU:   result = {31'b0, diff_ext[32]};
            `ALU_XOR:    result = a ^ b;
            `ALU_SR:     result = alt ? sra : a >> shamt;
            `ALU_OR:     result = a | b;
            `ALU_AND:    result = a & b;
            default:     result = '0;
        endcase
    end

endmodule

// ==== source/cpu.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module cpu (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::word_t     instruction,
    input  logic              read_valid,
    input  rv_pkg::word_t     read_data,
    output rv_pkg::dmem_req_t dmem,
    output rv_pkg::word_t     pc,
    output logic              halt
);
    localparam logic [1:0] WB_ALU  = 2'd0;
    localparam logic [1:0] WB_LOAD = 2'd1;
    localparam logic [1:0] WB_LINK = 2'd2;
    localparam logic [1:0] WB_IMM  = 2'd3;

    localparam logic [1:0] PC_SEQ = 2'd0;   // pc + 4
    localparam logic [1:0] PC_REL = 2'd1;   // pc + imm
    localparam logic [1:0] PC_REG = 2'd2;   // rs1 + imm, bit 0 cleared

    typedef enum logic [3:0] {
        WAIT, START, WRITE_BACK, COMPLETE, INCREMENT_PC,
        ACCESS_MEMORY_1, ACCESS_MEMORY_2, WRITE_MEMORY_1, WRITE_MEMORY_2,
        BRANCH, JUMP_LINK, LOAD_UPPER_IMM
    } state_t;

    state_t             state;
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    logic               alu_src;
    rv_pkg::alu_op_t    alu_op;
    logic [1:0]         wb_sel;
    logic [1:0]         pc_sel;
    rv_pkg::word_t      imm;
    rv_pkg::word_t      pc_next;
    rv_pkg::word_t      pc_target;
    rv_pkg::word_t      pc_plus4;
    rv_pkg::word_t      alu_result;
    rv_pkg::word_t      rs2_data;
    rv_pkg::word_t      wb_data;
    rv_pkg::word_t      load_data;
    rv_pkg::word_t      store_data;
    rv_pkg::alu_flags_t flags;
    logic [3:0]         byte_enable;
    logic               taken;

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic               funct7_alt;
    rv_pkg::reg_idx_t   rs1;
    rv_pkg::reg_idx_t   rs2;
    rv_pkg::reg_idx_t   rd;
    rv_pkg::word_t      imm_i;
    rv_pkg::word_t      imm_s;
    rv_pkg::word_t      imm_b;
    rv_pkg::word_t      imm_j;
    rv_pkg::word_t      imm_u;

    assign opcode     = instruction[6:0];
    assign rd         = instruction[11:7];
    assign funct3     = instruction[14:12];
    assign rs1        = instruction[19:15];
    assign rs2        = instruction[24:20];
    assign funct7_alt = instruction[30];

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                    instruction[11:8], 1'b0};
    assign imm_j = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                    instruction[30:21], 1'b0};
    assign imm_u = {instruction[31:12], 12'h0};

    datapath datapath_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .write_rb    (reg_write),
        .alu_control (alu_op),
        .alu_source  (alu_src),
        .rs_1        (rs1),
        .rs_2        (rs2),
        .rd_0        (rd),
        .write_data  (wb_data),
        .immediate   (imm),
        .alu_result  (alu_result),
        .flags       (flags),
        .rs2         (rs2_data)
    );

    load_store_align lsa_inst (
        .funct3      (funct3),
        .byte_offset (alu_result[1:0]),
        .store_data  (rs2_data),
        .load_word   (read_data),
        .write_data  (store_data),
        .byte_enable (byte_enable),
        .load_data   (load_data)
    );

    assign dmem.addr    = alu_result[`DMEM_ADDR_W-1:0];
    assign dmem.wdata   = store_data;
    assign dmem.byte_en = byte_enable;
    assign dmem.read    = mem_read;
    assign dmem.write   = mem_write;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (wb_sel)
            WB_ALU:  wb_data = alu_result;
            WB_LOAD: wb_data = load_data;
            WB_LINK: wb_data = pc_plus4;
            default: wb_data = imm;     // lui value or auipc sum
        endcase
    end

    always_comb begin
        case (pc_sel)
            PC_REL:  pc_target = pc + imm;
            PC_REG:  pc_target = {alu_result[31:1], 1'b0};
            default: pc_target = pc_plus4;
        endcase
    end

    always_comb begin
        case (funct3)
            3'h0:       taken = flags.zero;
            3'h1:       taken = !flags.zero;
            3'h4, 3'h6: taken = alu_result[0];      // blt, bltu
            3'h5, 3'h7: taken = !alu_result[0];     // bge, bgeu
            default:    taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= WAIT;
            pc        <= '0;
            reg_write <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            halt      <= 1'b0;
        end else begin
            case (state)
                WAIT: state <= START;
                START: begin
                    pc_sel  <= PC_SEQ;
                    wb_sel  <= WB_ALU;
                    alu_op  <= {1'b0, `ALU_ADDSUB};
                    alu_src <= 1'b1;
                    imm     <= imm_i;
                    case (opcode)
                        `RV_OP_R: begin
                            state   <= WRITE_BACK;
                            alu_op  <= {funct7_alt, funct3};
                            alu_src <= 1'b0;
                        end
                        `RV_OP_I: begin
                            state  <= WRITE_BACK;
                            alu_op <= {funct3 == `ALU_SR && funct7_alt, funct3};   // srai only
                        end
                        `RV_OP_LOAD: begin
                            state  <= ACCESS_MEMORY_1;
                            wb_sel <= WB_LOAD;
                        end
                        `RV_OP_STORE: begin
                            state <= WRITE_MEMORY_1;
                            imm   <= imm_s;
                        end
                        `RV_OP_BRANCH: begin
                            state   <= BRANCH;
                            alu_src <= 1'b0;
                            imm     <= imm_b;
                            if (funct3[2]) begin
                                alu_op <= {1'b0, funct3[1] ? `ALU_SLTU : `ALU_SLT};
                            end else begin
                                alu_op <= {1'b1, `ALU_ADDSUB};  // beq/bne read the zero flag
                            end
                        end
                        `RV_OP_JAL: begin
                            state  <= JUMP_LINK;
                            wb_sel <= WB_LINK;
                            pc_sel <= PC_REL;
                            imm    <= imm_j;
                        end
                        `RV_OP_JALR: begin
                            state  <= JUMP_LINK;
                            wb_sel <= WB_LINK;
                            pc_sel <= PC_REG;
                        end
                        `RV_OP_LUI: begin
                            state  <= LOAD_UPPER_IMM;
                            wb_sel <= WB_IMM;
                            imm    <= imm_u;
                        end
                        `RV_OP_AUIPC: begin
                            state  <= LOAD_UPPER_IMM;
                            wb_sel <= WB_IMM;
                            imm    <= pc + imm_u;
                        end
                        7'b0000000: halt <= 1'b1;   // stays in START on the same pc
                        default:    state <= COMPLETE;  // unknown opcode acts as nop
                    endcase
                end
                WRITE_BACK, JUMP_LINK, LOAD_UPPER_IMM: begin
                    state     <= COMPLETE;
                    reg_write <= 1'b1;
                end
                BRANCH: begin
                    state  <= COMPLETE;
                    pc_sel <= taken ? PC_REL : PC_SEQ;
                end
                ACCESS_MEMORY_1: begin
                    state    <= ACCESS_MEMORY_2;
                    mem_read <= 1'b1;
                end
                ACCESS_MEMORY_2: begin
                    mem_read <= 1'b0;
                    if (read_valid) begin
                        state     <= COMPLETE;
                        reg_write <= 1'b1;
                    end
                end
                WRITE_MEMORY_1: begin
                    state     <= WRITE_MEMORY_2;
                    mem_write <= 1'b1;
                end
                WRITE_MEMORY_2: begin
                    mem_write <= 1'b0;
                    if (read_valid) begin
                        state <= COMPLETE;
                    end
                end
                COMPLETE: begin
                    state     <= INCREMENT_PC;
                    reg_write <= 1'b0;
                    pc_next   <= pc_target;     // taken before rd is written
                end
                INCREMENT_PC: begin
                    state <= WAIT;
                    pc    <= pc_next;
                end
                default: state <= WAIT;
            endcase
        end
    end

    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem.read && dmem.write));

    read_answered: assert property (@(posedge clk) disable iff (!rst_n)
        mem_read |=> read_valid);

    state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {WAIT, START, WRITE_BACK, COMPLETE, INCREMENT_PC,
                      ACCESS_MEMORY_1, ACCESS_MEMORY_2, WRITE_MEMORY_1,
                      WRITE_MEMORY_2, BRANCH, JUMP_LINK, LOAD_UPPER_IMM});

endmodule

// ==== source/data_ram.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module data_ram (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::dmem_req_t req,
    output rv_pkg::word_t     read_data,
    output logic              read_valid,
    output rv_pkg::word_t     io_data,
    output logic              io_valid
);
    localparam int IDX_W = $clog2(`DMEM_WORDS);

    rv_pkg::word_t    mem [`DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             io_sel;

    assign idx    = req.addr[IDX_W+1:2];    // word-aligned index
    assign io_sel = req.addr[`DMEM_IO_BIT];

    always_ff @(posedge clk) begin
        if (req.write && !io_sel) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (req.byte_en[lane]) begin
                    mem[idx][8*lane +: 8] <= req.wdata[8*lane +: 8];
                end
            end
        end
        if (req.read) begin
            read_data <= mem[idx];  // held until the next read
        end
        if (req.write && io_sel) begin
            io_data <= req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_valid <= 1'b0;
            io_valid   <= 1'b0;
        end else begin
            read_valid <= req.read || req.write;    // stores are acknowledged too
            io_valid   <= req.write && io_sel;
        end
    end

endmodule

// ==== source/datapath.sv ====
`timescale 1ns/1ps

module datapath (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               write_rb,
    input  rv_pkg::alu_op_t    alu_control,
    input  logic               alu_source,
    input  rv_pkg::reg_idx_t   rs_1,
    input  rv_pkg::reg_idx_t   rs_2,
    input  rv_pkg::reg_idx_t   rd_0,
    input  rv_pkg::word_t      write_data,
    input  rv_pkg::word_t      immediate,
    output rv_pkg::word_t      alu_result,
    output rv_pkg::alu_flags_t flags,
    output rv_pkg::word_t      rs2
);
    rv_pkg::word_t rs1_data;
    rv_pkg::word_t operand_b;

    reg_bank reg_bank_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .write      (write_rb),
        .rs_1       (rs_1),
        .rs_2       (rs_2),
        .rd         (rd_0),
        .write_data (write_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2)
    );

    assign operand_b = alu_source ? immediate : rs2;    // high picks the immediate

    alu alu_inst (
        .a      (rs1_data),
        .b      (operand_b),
        .op     (alu_control),
        .result (alu_result),
        .flags  (flags)
    );

endmodule

// ==== source/load_store_align.sv ====
`timescale 1ns/1ps

module load_store_align (
    input  logic [2:0]    funct3,
    input  logic [1:0]    byte_offset,
    input  rv_pkg::word_t store_data,
    input  rv_pkg::word_t load_word,
    output rv_pkg::word_t write_data,
    output logic [3:0]    byte_enable,
    output rv_pkg::word_t load_data
);
    rv_pkg::word_t lane;    // addressed lane moved down to bit 0

    always_comb begin
        case (funct3[1:0])
            2'b00:   byte_enable = 4'b0001 << byte_offset;
            2'b01:   byte_enable = 4'b0011 << byte_offset;
            default: byte_enable = 4'b1111;
        endcase
    end

    always_comb begin
        case (byte_offset)
            2'd0:    write_data = store_data;
            2'd1:    write_data = {store_data[23:0], 8'h0};
            2'd2:    write_data = {store_data[15:0], 16'h0};
            default: write_data = {store_data[7:0], 24'h0};
        endcase
    end

    always_comb begin
        case (byte_offset)
            2'd0:    lane = load_word;
            2'd1:    lane = {8'h0, load_word[31:8]};
            2'd2:    lane = {16'h0, load_word[31:16]};
            default: lane = {24'h0, load_word[31:24]};
        endcase
    end

    always_comb begin
        case (funct3)
            3'h0:    load_data = {{24{lane[7]}}, lane[7:0]};      // lb
            3'h1:    load_data = {{16{lane[15]}}, lane[15:0]};    // lh
            3'h4:    load_data = {24'h0, lane[7:0]};              // lbu
            3'h5:    load_data = {16'h0, lane[15:0]};             // lhu
            default: load_data = lane;
        endcase
    end

endmodule

// ==== source/reg_bank.sv ====
`timescale 1ns/1ps

module reg_bank (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             write,
    input  rv_pkg::reg_idx_t rs_1,
    input  rv_pkg::reg_idx_t rs_2,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    write_data,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);
    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write && rd != '0) begin     // x0 writes are dropped
            regs[rd] <= write_data;
        end
    end

    assign rs1_data = regs[rs_1];
    assign rs2_data = regs[rs_2];

    x0_stays_zero: assert property (@(posedge clk) disable iff (!rst_n)
        regs[0] == '0);

endmodule

// ==== source/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

`define RV_OP_R      7'b0110011
`define RV_OP_I      7'b0010011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111

// alu function codes line up with funct3
`define ALU_ADDSUB 3'h0
`define ALU_SLL    3'h1
`define ALU_SLT    3'h2
`define ALU_SLTU   3'h3
`define ALU_XOR    3'h4
`define ALU_SR     3'h5
`define ALU_OR     3'h6
`define ALU_AND    3'h7

`define DMEM_ADDR_W 11
`define DMEM_WORDS  256
`define DMEM_IO_BIT (`DMEM_ADDR_W - 1)    // set means output port, not ram

`endif

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::word_t instruction,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t io_data,
    output logic          io_valid,
    output logic          halt
);
    rv_pkg::dmem_req_t dmem_req;
    rv_pkg::word_t     read_data;
    logic              read_valid;

    cpu cpu_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .read_valid  (read_valid),
        .read_data   (read_data),
        .dmem        (dmem_req),
        .pc          (pc),
        .halt        (halt)
    );

    data_ram data_ram_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (dmem_req),
        .read_data  (read_data),
        .read_valid (read_valid),
        .io_data    (io_data),
        .io_valid   (io_valid)
    );

endmodule

// ==== source/rv_pkg.sv ====
`include "rv_cfg.svh"

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;                  // {alternate bit, function code}
    typedef logic [`DMEM_ADDR_W-1:0] dmem_addr_t;   // byte address

    typedef struct packed {
        dmem_addr_t addr;
        word_t      wdata;      // already shifted into its lanes
        logic [3:0] byte_en;
        logic       read;
        logic       write;
    } dmem_req_t;

    typedef struct packed {
        logic zero;
        logic negative;
        logic overflow;
    } alu_flags_t;

endpackage

// ==== sources.f ====
+incdir+source
+incdir+test
source/rv_pkg.sv
source/alu.sv
source/reg_bank.sv
source/datapath.sv
source/load_store_align.sv
source/cpu.sv
source/data_ram.sv
source/rv_core_top.sv
test/tb_rv_core.sv

// ==== test/tb_rv_tasks.svh ====
`ifndef TB_RV_TASKS_SVH
`define TB_RV_TASKS_SVH

localparam int          PROG_WORDS = 256;
localparam logic [11:0] IO_OFFSET  = 12'h400;     // sets the io address bit

rv_pkg::word_t prog [PROG_WORDS];
int unsigned   prog_len;
rv_pkg::word_t model_regs [32];
logic [7:0]    model_mem [1024];
rv_pkg::word_t expected [$];

function automatic rv_pkg::word_t r_type(logic [2:0] f3, logic alt, logic [4:0] rd,
                                         logic [4:0] rs1, logic [4:0] rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `RV_OP_R};
endfunction

function automatic rv_pkg::word_t i_type(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                         logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic rv_pkg::word_t s_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
endfunction

function automatic rv_pkg::word_t b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
endfunction

function automatic rv_pkg::word_t u_type(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, op};
endfunction

function automatic rv_pkg::word_t j_type(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
endfunction

function automatic rv_pkg::word_t sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
endfunction

// integer results as the RV32I spec defines them
function automatic rv_pkg::word_t alu_rule(logic [2:0] f3, logic alt, rv_pkg::word_t a,
                                           rv_pkg::word_t b);
    case (f3)
        3'h0: return alt ? a - b : a + b;
        3'h1: return a << b[4:0];
        3'h2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'h3: return (a < b) ? 32'd1 : 32'd0;
        3'h4: return a ^ b;
        3'h5: begin
            if (alt) return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'h6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_rule(logic [2:0] f3, rv_pkg::word_t a, rv_pkg::word_t b);
    case (f3)
        3'h0: return a == b;
        3'h1: return a != b;
        3'h4: return $signed(a) < $signed(b);
        3'h5: return $signed(a) >= $signed(b);
        3'h6: return a < b;
        default: return a >= b;
    endcase
endfunction

// little-endian byte memory
function automatic rv_pkg::word_t load_rule(logic [2:0] f3, int unsigned addr);
    case (f3)
        3'h0: return {{24{model_mem[addr][7]}}, model_mem[addr]};
        3'h1: return {{16{model_mem[addr+1][7]}}, model_mem[addr+1], model_mem[addr]};
        3'h4: return {24'h0, model_mem[addr]};
        3'h5: return {16'h0, model_mem[addr+1], model_mem[addr]};
        default: return {model_mem[addr+3], model_mem[addr+2], model_mem[addr+1],
                         model_mem[addr]};
    endcase
endfunction

function automatic void store_rule(logic [2:0] f3, int unsigned addr, rv_pkg::word_t data);
    for (int i = 0; i < (1 << f3[1:0]); i++) begin
        model_mem[addr+i] = data[8*i +: 8];
    end
endfunction

function automatic void write_reg(logic [4:0] rd, rv_pkg::word_t value);
    if (rd != 5'd0) model_regs[rd] = value;
endfunction

function automatic void append(rv_pkg::word_t insn);
    prog[prog_len] = insn;
    prog_len++;
endfunction

function automatic void clear_program();
    for (int i = 0; i < PROG_WORDS; i++) begin
        prog[i] = '0;
    end
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;     // core reset clears the register bank
    end
    prog_len = 0;
    expected.delete();
endfunction

function automatic void alu_reg_op(logic [2:0] f3, logic alt, logic [4:0] rd,
                                   logic [4:0] rs1, logic [4:0] rs2);
    write_reg(rd, alu_rule(f3, alt, model_regs[rs1], model_regs[rs2]));
    append(r_type(f3, alt, rd, rs1, rs2));
endfunction

function automatic void alu_imm_op(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                   logic [11:0] imm);
    write_reg(rd, alu_rule(f3, f3 == 3'h5 && imm[10], model_regs[rs1], sext12(imm)));
    append(i_type(`RV_OP_I, f3, rd, rs1, imm));
endfunction

function automatic void upper_imm(logic [4:0] rd, logic [19:0] imm);
    write_reg(rd, {imm, 12'h0});
    append(u_type(`RV_OP_LUI, rd, imm));
endfunction

function automatic void load_const(logic [4:0] rd, rv_pkg::word_t value);
    rv_pkg::word_t upper;
    upper = (value + 32'h800) >> 12;    // rounds for the signed low part
    upper_imm(rd, upper[19:0]);
    alu_imm_op(3'h0, rd, rd, value[11:0]);
endfunction

function automatic void load_op(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                logic [11:0] imm);
    write_reg(rd, load_rule(f3, model_regs[rs1] + sext12(imm)));
    append(i_type(`RV_OP_LOAD, f3, rd, rs1, imm));
endfunction

function automatic void store_op(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                 logic [11:0] imm);
    store_rule(f3, model_regs[rs1] + sext12(imm), model_regs[rs2]);
    append(s_type(f3, rs1, rs2, imm));
endfunction

function automatic void write_port(logic [4:0] rs);
    append(s_type(3'h2, 5'd0, rs, IO_OFFSET));
    expected.push_back(model_regs[rs]);
endfunction

`endif

// ==== test/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_rv_core;

    logic          clk;
    logic          rst_n;
    rv_pkg::word_t instruction;
    rv_pkg::word_t pc;
    rv_pkg::word_t io_data;
    logic          io_valid;
    logic          halt;

    rv_pkg::word_t observed [$];
    int unsigned   checks = 0;
    int unsigned   errors = 0;
    int unsigned   cycle_budget = 200;   // margin, grows with every program

    `include "tb_rv_tasks.svh"

    rv_core_top rv_core_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .pc          (pc),
        .io_data     (io_data),
        .io_valid    (io_valid),
        .halt        (halt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        instruction <= prog[pc[9:2]];
    end

    always @(negedge clk) begin
        if (io_valid) observed.push_back(io_data);
    end

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles <= cycle_budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("TIMEOUT: the core did not reach halt within %0d cycles", cycle_budget);
        $display("Verification failed");
        $finish;
    end

    task automatic check_value(string what, rv_pkg::word_t got, rv_pkg::word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s is 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
        end
    endtask

    task automatic compare_outputs(string name);
        check_value({name, " port write count"}, observed.size(), expected.size());
        for (int i = 0; i < expected.size() && i < observed.size(); i++) begin
            check_value($sformatf("%s port write %0d", name, i), observed[i], expected[i]);
        end
    endtask

    // program is only swapped while the halted core sits on a zero word
    task automatic reset_core();
        append('0);
        cycle_budget += 12 * prog_len + 8;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        observed.delete();
    endtask

    task automatic wait_for_halt();
        @(negedge clk);
        while (!halt) @(negedge clk);
    endtask

    task automatic run_program();
        reset_core();
        wait_for_halt();
    endtask

    task automatic reset_state_test();
        clear_program();
        load_const(5'd1, $urandom());
        write_port(5'd1);
        reset_core();
        repeat (3) begin    // well before the first pc update
            @(negedge clk);
            check_value("pc after reset", pc, 32'd0);
            check_value("halt after reset", {31'b0, halt}, 32'd0);
            check_value("io_valid after reset", {31'b0, io_valid}, 32'd0);
        end
        wait_for_halt();
        compare_outputs("reset");
    endtask

    task automatic alu_ops_test();
        logic [11:0] imm;
        clear_program();
        for (int round = 0; round < 2; round++) begin
            load_const(5'd1, $urandom() | 32'h8000_0000);    // negative so sra and srl differ
            if (round == 0) load_const(5'd2, $urandom() & 32'h7fff_ffff);   // signs differ
            else alu_reg_op(3'h0, 1'b0, 5'd2, 5'd1, 5'd0);     // equal operands
            for (int f3 = 0; f3 < 8; f3++) begin
                alu_reg_op(3'(f3), 1'b0, 5'd3, 5'd1, 5'd2);
                write_port(5'd3);
            end
            alu_reg_op(3'h0, 1'b1, 5'd3, 5'd1, 5'd2);
            write_port(5'd3);
            alu_reg_op(3'h5, 1'b1, 5'd3, 5'd1, 5'd2);
            write_port(5'd3);
            for (int f3 = 0; f3 < 8; f3++) begin
                imm = 12'($urandom());
                if (f3 == 1 || f3 == 5) imm = {7'b0, imm[4:0]};
                alu_imm_op(3'(f3), 5'd4, 5'd1, imm);
                write_port(5'd4);
            end
            alu_imm_op(3'h5, 5'd4, 5'd1, {7'b0100000, 5'($urandom())});  // srai
            write_port(5'd4);
        end
        run_program();
        compare_outputs("alu");
    endtask

    task automatic load_store_test();
        clear_program();
        load_const(5'd1, $urandom());
        load_const(5'd2, $urandom());
        alu_imm_op(3'h0, 5'd5, 5'd0, 12'h100);
        store_op(3'h2, 5'd5, 5'd1, 12'd0);
        for (int i = 0; i < 4; i++) begin
            load_const(5'd3, $urandom());
            store_op(3'h0, 5'd5, 5'd3, 12'(4 + i));
        end
        store_op(3'h1, 5'd5, 5'd2, 12'd8);
        store_op(3'h1, 5'd5, 5'd1, 12'd10);
        store_op(3'h2, 5'd5, 5'd1, 12'd12);
        store_op(3'h0, 5'd5, 5'd2, 12'd13);     // partial writes over a full word
        store_op(3'h1, 5'd5, 5'd2, 12'd14);
        for (int off = 0; off < 16; off++) begin
            load_op(3'h0, 5'd6, 5'd5, 12'(off));
            write_port(5'd6);
            load_op(3'h4, 5'd6, 5'd5, 12'(off));
            write_port(5'd6);
            if (off % 2 == 0) begin
                load_op(3'h1, 5'd6, 5'd5, 12'(off));
                write_port(5'd6);
                load_op(3'h5, 5'd6, 5'd5, 12'(off));
                write_port(5'd6);
            end
            if (off % 4 == 0) begin
                load_op(3'h2, 5'd6, 5'd5, 12'(off));
                write_port(5'd6);
            end
        end
        run_program();
        compare_outputs("load/store");
    endtask

    task automatic branch_test();
        logic [2:0]    conds [6];
        logic [4:0]    lhs [3];
        logic [4:0]    rhs [3];
        rv_pkg::word_t marker;
        clear_program();
        conds = '{3'h0, 3'h1, 3'h4, 3'h5, 3'h6, 3'h7};
        lhs   = '{5'd2, 5'd1, 5'd2};
        rhs   = '{5'd2, 5'd2, 5'd1};
        load_const(5'd1, $urandom() | 32'h8000_0000);   // signed and unsigned order differ
        load_const(5'd2, $urandom() & 32'h7fff_ffff);
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                marker = 16 + 2 * (c * 3 + p);
                append(b_type(conds[c], lhs[p], rhs[p], 13'd12));
                append(i_type(`RV_OP_I, 3'h0, 5'd7, 5'd0, marker[11:0]));
                append(j_type(5'd0, 21'd8));
                append(i_type(`RV_OP_I, 3'h0, 5'd7, 5'd0, marker[11:0] + 12'd1));
                model_regs[7] = marker;
                if (branch_rule(conds[c], model_regs[lhs[p]], model_regs[rhs[p]])) begin
                    model_regs[7] = marker + 1;
                end
                write_port(5'd7);
            end
        end
        run_program();
        compare_outputs("branch");
    endtask

    task automatic jump_test();
        int unsigned here;
        logic [19:0] upper;
        clear_program();
        for (int i = 0; i < 3; i++) begin
            upper = 20'($urandom());
            upper_imm(5'd8, upper);
            write_port(5'd8);
            here = prog_len * 4;
            append(u_type(`RV_OP_AUIPC, 5'd8, upper));
            model_regs[8] = here + {upper, 12'h0};
            write_port(5'd8);
        end
        here = prog_len * 4;
        append(j_type(5'd9, 21'd8));
        append(i_type(`RV_OP_I, 3'h0, 5'd10, 5'd0, 12'd1));    // jumped over
        model_regs[9] = here + 4;
        write_port(5'd9);
        write_port(5'd10);
        here = prog_len * 4;
        alu_imm_op(3'h0, 5'd11, 5'd0, 12'(here + 13));      // bit 0 gets dropped
        append(i_type(`RV_OP_JALR, 3'h0, 5'd12, 5'd11, 12'd0));
        append(i_type(`RV_OP_I, 3'h0, 5'd10, 5'd0, 12'd2));    // jumped over
        model_regs[12] = here + 8;
        write_port(5'd12);
        write_port(5'd10);
        run_program();
        compare_outputs("jump");
    endtask

    task automatic halt_hold_test();
        rv_pkg::word_t halt_pc;
        clear_program();
        load_const(5'd1, $urandom());
        write_port(5'd1);
        run_program();
        halt_pc = (prog_len - 1) * 4;
        compare_outputs("halt");
        cycle_budget += 60;
        repeat (50) begin
            @(negedge clk);
            check_value("halt while halted", {31'b0, halt}, 32'd1);
            check_value("pc while halted", pc, halt_pc);
            check_value("io_valid while halted", {31'b0, io_valid}, 32'd0);
        end
        check_value("port writes after halt", observed.size(), expected.size());
    endtask

    initial begin
        void'($urandom(32'h9d16_7200));
        rst_n       = 1'b0;
        instruction = '0;
        clear_program();
        reset_state_test();
        alu_ops_test();
        load_store_test();
        branch_test();
        jump_test();
        halt_hold_test();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
